//--- hdl/flash_pkg.sv
package flash_pkg;

	// ********************
	// bus and flash geometry.
	// ********************

	// wishbone byte address width.
	localparam int WB_ADR_WIDTH = 32;
	// flash halfword address width.
	localparam int FLASH_ADR_WIDTH = 22;
	// the flash data bus is one halfword.
	localparam int FLASH_DATA_WIDTH = 16;

	// ********************
	// read timing.
	// ********************

	// counter index at which the halfword is sampled.
	// 13 cycles of 10 ns cover a 110 ns part with margin.
	localparam int FLASH_WAIT_CYCLES = 12;
	// wide enough to hold FLASH_WAIT_CYCLES.
	localparam int FLASH_WAIT_WIDTH = 4;

	// controller states.
	localparam logic [1:0] FLASH_ST_IDLE = 2'd0;
	localparam logic [1:0] FLASH_ST_READ = 2'd1;
	localparam logic [1:0] FLASH_ST_ACK  = 2'd2;

	// arbiter grant codes.
	localparam logic GRANT_IBUS = 1'b0;
	localparam logic GRANT_DBUS = 1'b1;

	// ********************
	// assembled read word.
	// ********************

	// seen whole by wishbone, filled one halfword at a time by the controller.
	// hi is the first halfword read, lo the second.
	typedef union packed {
		logic [2*FLASH_DATA_WIDTH-1:0] word;
		struct packed {
			logic [FLASH_DATA_WIDTH-1:0] hi;
			logic [FLASH_DATA_WIDTH-1:0] lo;
		} half;
	} flash_word_t;

endpackage

//--- hdl/norflash16.sv
`timescale 1ns/10ps

module norflash16 (
	input  logic                                    sys_clk,
	input  logic                                    sys_rst,

	// wishbone slave, reads only.
	input  logic [flash_pkg::WB_ADR_WIDTH-1:0]      wb_adr_i,
	input  logic                                    wb_cyc_i,
	input  logic                                    wb_stb_i,
	output logic [$bits(flash_pkg::flash_word_t)-1:0] wb_dat_o,
	output logic                                    wb_ack_o,

	// flash chip pins.
	output logic [flash_pkg::FLASH_ADR_WIDTH-1:0]   flash_adr_o,
	input  logic [flash_pkg::FLASH_DATA_WIDTH-1:0]  flash_d_i
);

	import flash_pkg::*;

	// upper flash address bits, from the wishbone word index.
	logic [FLASH_ADR_WIDTH-2:0]  flash_adr_msb;
	// selects the first or second halfword of the word.
	logic                        flash_adr_lsb;
	// assembled read word.
	flash_word_t                 rd_word;
	// flash data with its two bytes exchanged.
	logic [FLASH_DATA_WIDTH-1:0] flash_d_swap;
	// wishbone request seen.
	logic                        wb_req;
	// wait counter.
	logic [FLASH_WAIT_WIDTH-1:0] counter;
	logic                        counter_en;
	logic                        counter_done;
	// store the current halfword.
	logic                        load;
	// fsm state.
	logic [1:0]                  state;
	logic [1:0]                  next_state;

	assign wb_req = wb_cyc_i && wb_stb_i;
	assign flash_d_swap = {flash_d_i[7:0], flash_d_i[15:8]};
	assign flash_adr_o = {flash_adr_msb, flash_adr_lsb};
	assign wb_dat_o = rd_word.word;

	// ********************
	// flash address.
	// ********************

	// only loaded while a cycle is active, so the pins stay quiet otherwise.
	// wishbone bits 21..2 give the word index; the top flash bit stays zero.
	always_ff @(posedge sys_clk) begin
		if (wb_req) begin
			flash_adr_msb <= {1'b0, wb_adr_i[FLASH_ADR_WIDTH-1:2]};
		end
	end

	// first halfword at lsb 0, then toggle after each sample.
	// two toggles per word bring it back to 0.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			flash_adr_lsb <= 1'b0;
		end else if (load) begin
			flash_adr_lsb <= ~flash_adr_lsb;
		end
	end

	// ********************
	// read data.
	// ********************

	// lsb 0 fills the upper half, lsb 1 the lower half.
	always_ff @(posedge sys_clk) begin
		if (load) begin
			if (!flash_adr_lsb) begin
				rd_word.half.hi <= flash_d_swap;
			end else begin
				rd_word.half.lo <= flash_d_swap;
			end
		end
	end

	// ********************
	// wait counter.
	// ********************

	// counts 0..FLASH_WAIT_CYCLES while enabled, then wraps for the next halfword.
	assign counter_done = (counter == FLASH_WAIT_WIDTH'(FLASH_WAIT_CYCLES));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			counter <= '0;
		end else if (counter_en && !counter_done) begin
			counter <= counter + 1'b1;
		end else begin
			counter <= '0;
		end
	end

	// ********************
	// control fsm.
	// ********************

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= FLASH_ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		counter_en = 1'b0;
		load = 1'b0;
		wb_ack_o = 1'b0;
		case (state)
			// wait for a request.
			FLASH_ST_IDLE: begin
				if (wb_req) begin
					next_state = FLASH_ST_READ;
				end
			end
			// two timed halfword reads.
			FLASH_ST_READ: begin
				counter_en = 1'b1;
				if (counter_done) begin
					load = 1'b1;
					// second halfword done.
					if (flash_adr_lsb) begin
						next_state = FLASH_ST_ACK;
					end
				end
			end
			// one ack cycle, word is complete.
			FLASH_ST_ACK: begin
				wb_ack_o = 1'b1;
				next_state = FLASH_ST_IDLE;
			end
			default: begin
				next_state = FLASH_ST_IDLE;
			end
		endcase
	end

endmodule

//--- hdl/wb_flash_arbiter.sv
`timescale 1ns/10ps

module wb_flash_arbiter (
	input  logic                                      sys_clk,
	input  logic                                      sys_rst,

	// instruction fetch master.
	input  logic [flash_pkg::WB_ADR_WIDTH-1:0]        ibus_adr_i,
	input  logic                                      ibus_cyc_i,
	input  logic                                      ibus_stb_i,
	output logic [$bits(flash_pkg::flash_word_t)-1:0] ibus_dat_o,
	output logic                                      ibus_ack_o,

	// data master.
	input  logic [flash_pkg::WB_ADR_WIDTH-1:0]        dbus_adr_i,
	input  logic                                      dbus_cyc_i,
	input  logic                                      dbus_stb_i,
	output logic [$bits(flash_pkg::flash_word_t)-1:0] dbus_dat_o,
	output logic                                      dbus_ack_o,

	// shared slave port.
	output logic [flash_pkg::WB_ADR_WIDTH-1:0]        s_adr_o,
	output logic                                      s_cyc_o,
	output logic                                      s_stb_o,
	input  logic [$bits(flash_pkg::flash_word_t)-1:0] s_dat_i,
	input  logic                                      s_ack_i
);

	import flash_pkg::*;

	// current owner of the slave.
	logic grant;
	// owner for the next cycle.
	logic grant_next;

	// ********************
	// grant.
	// ********************

	// the owner keeps the slave as long as it holds cyc.
	// once it lets go, a waiting master takes over on the next edge.
	// with both masters busy this alternates, since the previous
	// owner must drop cyc before it can win again.
	always_comb begin
		grant_next = grant;
		case (grant)
			GRANT_IBUS: begin
				if (!ibus_cyc_i && dbus_cyc_i) begin
					grant_next = GRANT_DBUS;
				end
			end
			GRANT_DBUS: begin
				if (!dbus_cyc_i && ibus_cyc_i) begin
					grant_next = GRANT_IBUS;
				end
			end
			default: begin
				grant_next = GRANT_IBUS;
			end
		endcase
	end

	// instruction fetch owns the slave out of reset.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			grant <= GRANT_IBUS;
		end else begin
			grant <= grant_next;
		end
	end

	// ********************
	// request path.
	// ********************

	// only the owner's address and strobes reach the controller.
	// a master without the grant just waits with stb high.
	always_comb begin
		if (grant == GRANT_DBUS) begin
			s_adr_o = dbus_adr_i;
			s_cyc_o = dbus_cyc_i;
			s_stb_o = dbus_stb_i;
		end else begin
			s_adr_o = ibus_adr_i;
			s_cyc_o = ibus_cyc_i;
			s_stb_o = ibus_stb_i;
		end
	end

	// ********************
	// response path.
	// ********************

	// read data is shared, it is only valid with ack.
	assign ibus_dat_o = s_dat_i;
	assign dbus_dat_o = s_dat_i;

	// ack goes to the owner alone.
	// the other master never sees a completion that is not its own.
	assign ibus_ack_o = s_ack_i && (grant == GRANT_IBUS);
	assign dbus_ack_o = s_ack_i && (grant == GRANT_DBUS);

endmodule

//--- hdl/flash_subsys_top.sv
`timescale 1ns/10ps

module flash_subsys_top (
	input  logic                                      sys_clk,
	input  logic                                      sys_rst,

	// instruction fetch port.
	input  logic [flash_pkg::WB_ADR_WIDTH-1:0]        ibus_adr_i,
	input  logic                                      ibus_cyc_i,
	input  logic                                      ibus_stb_i,
	output logic [$bits(flash_pkg::flash_word_t)-1:0] ibus_dat_o,
	output logic                                      ibus_ack_o,

	// data port.
	input  logic [flash_pkg::WB_ADR_WIDTH-1:0]        dbus_adr_i,
	input  logic                                      dbus_cyc_i,
	input  logic                                      dbus_stb_i,
	output logic [$bits(flash_pkg::flash_word_t)-1:0] dbus_dat_o,
	output logic                                      dbus_ack_o,

	// nor flash pins, chip controls tied active on the board.
	output logic [flash_pkg::FLASH_ADR_WIDTH-1:0]     flash_adr_o,
	input  logic [flash_pkg::FLASH_DATA_WIDTH-1:0]    flash_d_i
);

	import flash_pkg::*;

	// ********************
	// arbiter to controller.
	// ********************

	logic [WB_ADR_WIDTH-1:0]        s_adr;
	logic                           s_cyc;
	logic                           s_stb;
	logic [$bits(flash_word_t)-1:0] s_dat;
	logic                           s_ack;

	// picks one master at a time.
	wb_flash_arbiter u_arbiter (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.ibus_adr_i (ibus_adr_i),
		.ibus_cyc_i (ibus_cyc_i),
		.ibus_stb_i (ibus_stb_i),
		.ibus_dat_o (ibus_dat_o),
		.ibus_ack_o (ibus_ack_o),
		.dbus_adr_i (dbus_adr_i),
		.dbus_cyc_i (dbus_cyc_i),
		.dbus_stb_i (dbus_stb_i),
		.dbus_dat_o (dbus_dat_o),
		.dbus_ack_o (dbus_ack_o),
		.s_adr_o    (s_adr),
		.s_cyc_o    (s_cyc),
		.s_stb_o    (s_stb),
		.s_dat_i    (s_dat),
		.s_ack_i    (s_ack)
	);

	// ********************
	// flash controller.
	// ********************

	// two halfword reads per wishbone word.
	norflash16 u_norflash (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.wb_adr_i    (s_adr),
		.wb_cyc_i    (s_cyc),
		.wb_stb_i    (s_stb),
		.wb_dat_o    (s_dat),
		.wb_ack_o    (s_ack),
		.flash_adr_o (flash_adr_o),
		.flash_d_i   (flash_d_i)
	);

endmodule

//--- verification/flash_chip_model.sv
`timescale 1ns/10ps

module flash_chip_model (
	input  logic [flash_pkg::FLASH_ADR_WIDTH-1:0]  adr_i,
	output logic [flash_pkg::FLASH_DATA_WIDTH-1:0] d_o
);

	import flash_pkg::*;

	// access time of a 110 ns part.
	localparam int ACCESS_NS = 110;

	// address as it was one access time ago.
	logic [FLASH_ADR_WIDTH-1:0] adr_settled;

	// ********************
	// array contents.
	// ********************

	// low 16 bits of a * 0x9e37, then xor 0x5a5a.
	function automatic logic [FLASH_DATA_WIDTH-1:0] contents(
		input logic [FLASH_ADR_WIDTH-1:0] a
	);
		logic [31:0] prod;
		prod = 32'(a) * 32'h9e37;
		return prod[15:0] ^ 16'h5a5a;
	endfunction

	// ********************
	// access delay.
	// ********************

	// transport delay of the address.
	always @(adr_i) begin
		adr_settled <= #(ACCESS_NS) adr_i;
	end

	// data is only driven once the address has been stable for the access time.
	// any earlier sample reads x.
	assign d_o = (adr_settled === adr_i) ? contents(adr_i) : 'x;

endmodule

//--- verification/tb_flash_subsys.sv
`timescale 1ns/10ps

module tb_flash_subsys;

	import flash_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS = 10;
	// one word read plus a regrant and the idle gap.
	localparam int READ_BUDGET = 2 * (FLASH_WAIT_CYCLES + 1) + 4;
	// two reads per row at most.
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 2 * READ_BUDGET + RESET_CYCLES;

	localparam int PORT_I = 0;
	localparam int PORT_D = 1;
	localparam int PORT_BOTH = 2;

	// edge randomizes bits 31..22 and 1..0, all draws the whole address.
	localparam int RAND_NONE = 0;
	localparam int RAND_EDGE = 1;
	localparam int RAND_ALL = 2;

	// ********************
	// test table.
	// ********************

	// columns are name, port, ibus byte address, dbus byte address, random kind.
	string test_name [NUM_TESTS] = '{
		"reset_ibus", "single_dbus", "b2b_ibus_a", "b2b_ibus_b", "b2b_ibus_c",
		"both_same_cycle", "both_again", "rand_edge_ibus", "rand_edge_dbus", "rand_any"
	};
	int test_port [NUM_TESTS] = '{
		PORT_I, PORT_D, PORT_I, PORT_I, PORT_I,
		PORT_BOTH, PORT_BOTH, PORT_I, PORT_D, PORT_BOTH
	};
	logic [31:0] test_adr_i [NUM_TESTS] = '{
		32'h0000_0000, 32'h0000_0000, 32'h0000_0100, 32'h0000_0104, 32'h003f_fffc,
		32'h0000_0040, 32'h0000_2000, 32'h0001_5550, 32'h0000_0000, 32'h0000_0000
	};
	logic [31:0] test_adr_d [NUM_TESTS] = '{
		32'h0000_0000, 32'h0000_1234, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
		32'h0002_0a08, 32'h0000_2004, 32'h0000_0000, 32'h0001_5550, 32'h0000_0000
	};
	int test_rand [NUM_TESTS] = '{
		RAND_NONE, RAND_NONE, RAND_NONE, RAND_NONE, RAND_NONE,
		RAND_NONE, RAND_NONE, RAND_EDGE, RAND_EDGE, RAND_ALL
	};

	logic                           sys_clk;
	logic                           sys_rst;
	logic [WB_ADR_WIDTH-1:0]        ibus_adr;
	logic                           ibus_cyc;
	logic                           ibus_stb;
	logic [$bits(flash_word_t)-1:0] ibus_dat;
	logic                           ibus_ack;
	logic [WB_ADR_WIDTH-1:0]        dbus_adr;
	logic                           dbus_cyc;
	logic                           dbus_stb;
	logic [$bits(flash_word_t)-1:0] dbus_dat;
	logic                           dbus_ack;
	logic [FLASH_ADR_WIDTH-1:0]     flash_adr;
	logic [FLASH_DATA_WIDTH-1:0]    flash_d;

	logic [31:0] lfsr;
	int errors = 0;
	int failed_tests = 0;
	// acks seen by the monitor against reads issued.
	int ibus_acks = 0;
	int dbus_acks = 0;
	int ibus_reads = 0;
	int dbus_reads = 0;

	flash_subsys_top dut0 (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.ibus_adr_i (ibus_adr),
		.ibus_cyc_i (ibus_cyc),
		.ibus_stb_i (ibus_stb),
		.ibus_dat_o (ibus_dat),
		.ibus_ack_o (ibus_ack),
		.dbus_adr_i (dbus_adr),
		.dbus_cyc_i (dbus_cyc),
		.dbus_stb_i (dbus_stb),
		.dbus_dat_o (dbus_dat),
		.dbus_ack_o (dbus_ack),
		.flash_adr_o(flash_adr),
		.flash_d_i  (flash_d)
	);

	flash_chip_model u_flash (
		.adr_i(flash_adr),
		.d_o  (flash_d)
	);

	initial sys_clk = 1'b0;
	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// ********************
	// reference model.
	// ********************

	// galois lfsr, taps of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [15:0] swap_bytes(input logic [15:0] h);
		return {h[7:0], h[15:8]};
	endfunction

	// flash contents, a * 0x9e37 xor 0x5a5a.
	function automatic logic [15:0] flash_halfword(input logic [21:0] a);
		logic [31:0] prod;
		prod = {10'd0, a} * 32'h9e37;
		return prod[15:0] ^ 16'h5a5a;
	endfunction

	// halfwords 2w and 2w+1 of word index w, each byte-swapped.
	function automatic logic [31:0] expected_word(input logic [31:0] adr);
		logic [21:0] base;
		base = {1'b0, adr[21:2], 1'b0};
		return {swap_bytes(flash_halfword(base)), swap_bytes(flash_halfword(base | 22'd1))};
	endfunction

	// one lfsr step per bit taken.
	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// ********************
	// master drivers.
	// ********************

	// entered on a falling edge, drives both masters and holds until each ack.
	task automatic run_test(input int idx);
		logic [31:0] adr_i;
		logic [31:0] adr_d;
		logic [31:0] rnd;
		logic [31:0] got_i;
		logic [31:0] got_d;
		logic use_i;
		logic use_d;
		logic done_i;
		logic done_d;
		int bad;

		adr_i = test_adr_i[idx];
		adr_d = test_adr_d[idx];
		if (test_rand[idx] == RAND_EDGE) begin
			draw_bits(12, rnd);
			adr_i = {rnd[11:2], adr_i[21:2], rnd[1:0]};
			draw_bits(12, rnd);
			adr_d = {rnd[11:2], adr_d[21:2], rnd[1:0]};
		end else if (test_rand[idx] == RAND_ALL) begin
			draw_bits(32, adr_i);
			draw_bits(32, adr_d);
		end
		use_i = (test_port[idx] != PORT_D);
		use_d = (test_port[idx] != PORT_I);
		done_i = !use_i;
		done_d = !use_d;
		got_i = '0;
		got_d = '0;
		bad = 0;
		if (use_i) begin
			ibus_adr = adr_i;
			ibus_cyc = 1'b1;
			ibus_stb = 1'b1;
			ibus_reads++;
		end
		if (use_d) begin
			dbus_adr = adr_d;
			dbus_cyc = 1'b1;
			dbus_stb = 1'b1;
			dbus_reads++;
		end
		while (!(done_i && done_d)) begin
			@(negedge sys_clk);
			if (ibus_ack) begin
				if (done_i) begin
					bad++;
					$display("%s: ibus acked with no read of its own pending", test_name[idx]);
				end else begin
					got_i = ibus_dat;
					done_i = 1'b1;
					ibus_cyc = 1'b0;
					ibus_stb = 1'b0;
				end
			end
			if (dbus_ack) begin
				if (done_d) begin
					bad++;
					$display("%s: dbus acked with no read of its own pending", test_name[idx]);
				end else begin
					got_d = dbus_dat;
					done_d = 1'b1;
					dbus_cyc = 1'b0;
					dbus_stb = 1'b0;
				end
			end
		end
		// a mismatch also catches x from a sample taken too early.
		if (use_i && (got_i !== expected_word(adr_i))) begin
			bad++;
			$display("FAIL %s ibus @%h: expected %h, actual %h",
				test_name[idx], adr_i, expected_word(adr_i), got_i);
		end
		if (use_d && (got_d !== expected_word(adr_d))) begin
			bad++;
			$display("FAIL %s dbus @%h: expected %h, actual %h",
				test_name[idx], adr_d, expected_word(adr_d), got_d);
		end
		if (bad == 0) begin
			$display("ok   %s", test_name[idx]);
		end else begin
			failed_tests++;
		end
		errors += bad;
	endtask

	// ********************
	// ack monitor.
	// ********************

	// acks are exclusive, and none may show while reset is held.
	always @(negedge sys_clk) begin
		if (sys_rst && (ibus_ack || dbus_ack)) begin
			errors++;
			$display("ack seen while reset is asserted");
		end
		if (ibus_ack && dbus_ack) begin
			errors++;
			$display("ibus and dbus acked in the same cycle");
		end
		if (ibus_ack) begin
			ibus_acks++;
		end
		if (dbus_ack) begin
			dbus_acks++;
		end
	end

	// ********************
	// main sequence.
	// ********************

	initial begin
		ibus_adr = '0;
		ibus_cyc = 1'b0;
		ibus_stb = 1'b0;
		dbus_adr = '0;
		dbus_cyc = 1'b0;
		dbus_stb = 1'b0;
		sys_rst = 1'b1;
		lfsr = 32'h33c2_1238;
		repeat (RESET_CYCLES) @(negedge sys_clk);
		sys_rst = 1'b0;
		// the first read starts on the same edge that releases reset.
		for (int i = 0; i < NUM_TESTS; i++) begin
			run_test(i);
			@(negedge sys_clk);
		end
		if (ibus_acks != ibus_reads) begin
			errors++;
			$display("ibus got %0d acks for %0d reads", ibus_acks, ibus_reads);
		end
		if (dbus_acks != dbus_reads) begin
			errors++;
			$display("dbus got %0d acks for %0d reads", dbus_acks, dbus_reads);
		end
		$display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog sized from the table length and the read time.
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, reads still pending after %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- compile.f
hdl/flash_pkg.sv
hdl/norflash16.sv
hdl/wb_flash_arbiter.sv
hdl/flash_subsys_top.sv
verification/flash_chip_model.sv
verification/tb_flash_subsys.sv

//--- Makefile
# verilator build and run of the flash subsystem testbench.
TOP := tb_flash_subsys

.PHONY: sim clean

# the run output goes to the terminal, the grep decides the exit status.
sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
